// File: tests/rv_core_golden.txt
// Program words from address 0, four per line; record count at word 0C0
// Records from word 0C1: pc we rd wdata illegal; rd and wdata count only when we is 1
@000
00500093 FFD00113 002081B3 40110233
001122B3 0020A333 FFE12393 00F0C413
0300E493 0F017513 123455B7 0015C633
001266B3 0045F733 00708013 001007B3
00F08463 00100813 00F09463 00209463
00200813 00208463 0000000B 7FF00813
410008B3 FE081CE3
@0C0
00000019
00000000 1 01 00000005 0
00000004 1 02 FFFFFFFD 0
00000008 1 03 00000002 0
0000000C 1 04 FFFFFFF8 0
00000010 1 05 00000001 0
00000014 1 06 00000000 0
00000018 1 07 00000001 0
0000001C 1 08 0000000A 0
00000020 1 09 00000035 0
00000024 1 0A 000000F0 0
00000028 1 0B 12345000 0
0000002C 1 0C 12345005 0
00000030 1 0D FFFFFFFD 0
00000034 1 0E 12345000 0
00000038 0 00 00000000 0
0000003C 1 0F 00000005 0
00000040 0 00 00000000 0
00000048 0 00 00000000 0
0000004C 0 00 00000000 0
00000054 0 00 00000000 0
00000058 0 00 00000000 1
0000005C 1 10 000007FF 0
00000060 1 11 FFFFF801 0
00000064 0 00 00000000 0
0000005C 1 10 000007FF 0

// File: files.f
source/rv_core_pkg.sv
source/rv_isa_pkg.sv
source/rv_stage_if.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu_branch.sv
source/rv_writeback.sv
source/rv_core.sv
tests/rv_core_asserts.sv
tests/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
# The exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f files.f --top-module rv_core_tb -Mdir build/obj_dir \
  && ./build/obj_dir/Vrv_core_tb \
  || { echo "build or simulation failed"; exit 1; }

// File: tests/rv_core_tb.sv
////////////////////
// Testbench for the RV32I subset core
// Serves the program from the golden file and checks every retire record
////////////////////

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // Golden file layout, in words
  ////////////////////

  localparam int unsigned GOLDEN_DEPTH  = 512;
  localparam int unsigned PROG_DEPTH    = 192;
  localparam logic [8:0]  REC_COUNT_IDX = 9'h0C0;
  localparam logic [8:0]  REC_BASE_IDX  = 9'h0C1;
  // pc, we, rd, wdata, illegal
  localparam int unsigned REC_WORDS     = 5;
  localparam int unsigned REC_MAX       = 60;
  localparam int unsigned RESET_CYCLES  = 8;

  logic                  clk;
  logic                  rst_ni;
  rv_core_pkg::word_t    boot_addr_i;
  logic                  instr_req_o;
  rv_core_pkg::word_t    instr_addr_o;
  logic                  instr_rvalid_i;
  rv_core_pkg::word_t    instr_rdata_i;
  logic                  retire_valid_o;
  rv_core_pkg::word_t    retire_pc_o;
  logic                  retire_we_o;
  rv_core_pkg::reg_idx_t retire_rd_o;
  rv_core_pkg::word_t    retire_wdata_o;
  logic                  retire_illegal_o;

  rv_core_pkg::word_t golden_mem [GOLDEN_DEPTH];
  int unsigned        num_records;
  int                 seed;

  rv_core #(
    .RV32E ( 1'b0 )
  ) i_rv_core (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .boot_addr_i      ( boot_addr_i      ),
    .instr_req_o      ( instr_req_o      ),
    .instr_addr_o     ( instr_addr_o     ),
    .instr_rvalid_i   ( instr_rvalid_i   ),
    .instr_rdata_i    ( instr_rdata_i    ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_pc_o      ( retire_pc_o      ),
    .retire_we_o      ( retire_we_o      ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_wdata_o   ( retire_wdata_o   ),
    .retire_illegal_o ( retire_illegal_o )
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // Outputs are read 1 ns after the edge
  task automatic wait_retire();
    do begin
      @(posedge clk);
      #1;
    end while (!retire_valid_o);
  endtask

  function automatic rv_core_pkg::word_t read_program(input rv_core_pkg::word_t addr);
    if (addr[31:2] < 30'(PROG_DEPTH)) begin
      return golden_mem[addr[10:2]];
    end
    // Beyond the program area
    return 32'hBAD0_0000 ^ addr;
  endfunction

  ////////////////////
  // Instruction memory
  ////////////////////

  // One answer per request, 1 to 4 cycles later
  initial begin : imem_model
    int                 delay_cnt;
    logic               first_req;
    rv_core_pkg::word_t req_addr;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    delay_cnt      = 0;
    first_req      = 1'b1;
    req_addr       = '0;
    seed           = 94;
    forever begin
      @(posedge clk);
      #1;
      instr_rvalid_i = 1'b0;
      if (delay_cnt > 0) begin
        delay_cnt = delay_cnt - 1;
        if (delay_cnt == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = read_program(req_addr);
        end
      end
      if (instr_req_o) begin
        if (delay_cnt > 0) begin
          $display("new instruction request while the previous one is outstanding");
          abort_run();
        end
        // Boot fetch comes from address 0
        if (first_req) begin
          check_value("first_req_addr", 32'h0, instr_addr_o);
        end
        first_req = 1'b0;
        req_addr  = instr_addr_o;
        delay_cnt = 1 + ($random(seed) & 3);
      end
    end
  end

  ////////////////////
  // Reset and retire checks
  ////////////////////

  initial begin : main_seq
    logic [8:0] base;
    rst_ni      = 1'b0;
    boot_addr_i = '0;
    for (int i = 0; i < GOLDEN_DEPTH; i++) begin
      golden_mem[i[8:0]] = 32'hBAD0_0000 | 32'(i);
    end
    $readmemh("tests/rv_core_golden.txt", golden_mem);
    num_records = golden_mem[REC_COUNT_IDX];
    if (num_records == 0 || num_records > REC_MAX) begin
      $display("golden file has no usable record count");
      abort_run();
    end
    // Quiet core while held in reset
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("reset_retire_valid", 32'h0, 32'(retire_valid_o));
      check_value("reset_instr_req", 32'h0, 32'(instr_req_o));
    end
    rst_ni = 1'b1;
    for (int unsigned rec = 0; rec < num_records; rec++) begin
      base = 9'(REC_BASE_IDX + rec * REC_WORDS);
      wait_retire();
      check_value($sformatf("retire%0d_pc", rec), golden_mem[base], retire_pc_o);
      check_value($sformatf("retire%0d_we", rec), golden_mem[base + 9'd1],
                  32'(retire_we_o));
      check_value($sformatf("retire%0d_illegal", rec), golden_mem[base + 9'd4],
                  32'(retire_illegal_o));
      // rd and wdata only for a committed write
      if (golden_mem[base + 9'd1] != 32'h0) begin
        check_value($sformatf("retire%0d_rd", rec), golden_mem[base + 9'd2],
                    32'(retire_rd_o));
        check_value($sformatf("retire%0d_wdata", rec), golden_mem[base + 9'd3],
                    retire_wdata_o);
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

  // At most 4 cycles of memory delay plus 4 from the answer to the next request
  initial begin : watchdog
    int unsigned cycle_cnt;
    int unsigned cycle_limit;
    cycle_cnt = 0;
    @(posedge rst_ni);
    cycle_limit = num_records * 8 + 50;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: retire sequence not complete after %0d cycles", cycle_limit);
    abort_run();
  end

endmodule

// File: tests/rv_core_asserts.sv
////////////////////
// Concurrent checks on fetch and retire timing of the core
// Bound into rv_core on its instruction and retire ports
////////////////////

module rv_core_asserts (
  input logic                  clk,
  input logic                  rst_ni,
  input logic                  req_i,
  input logic                  rvalid_i,
  input logic                  retire_valid_i,
  input logic                  retire_we_i,
  input rv_core_pkg::reg_idx_t retire_rd_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Set by a request, cleared by its answer
  logic pending_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (req_i) begin
      pending_q <= 1'b1;
    end else if (rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Retire rises 3 cycles after the edge that takes the word, seen at the 4th edge
  a_retire_after_rvalid: assert property (
    @(posedge clk) disable iff (!rst_ni) $past(rvalid_i, 4) |-> retire_valid_i
  ) else $error("retire missing 3 cycles after instr_rvalid_i");

  a_rvalid_before_retire: assert property (
    @(posedge clk) disable iff (!rst_ni) retire_valid_i |-> $past(rvalid_i, 4)
  ) else $error("retire without instr_rvalid_i 3 cycles before");

  a_single_request: assert property (
    @(posedge clk) disable iff (!rst_ni) req_i |-> !pending_q
  ) else $error("instr_req_o while a request is outstanding");

  // x0 is never reported as written
  a_we_rd_nonzero: assert property (
    @(posedge clk) disable iff (!rst_ni)
      (retire_valid_i && retire_we_i) |-> (retire_rd_i != '0)
  ) else $error("retire_we_o with retire_rd_o of zero");

endmodule

bind rv_core rv_core_asserts i_rv_core_asserts (
  .clk            ( clk            ),
  .rst_ni         ( rst_ni         ),
  .req_i          ( instr_req_o    ),
  .rvalid_i       ( instr_rvalid_i ),
  .retire_valid_i ( retire_valid_o ),
  .retire_we_i    ( retire_we_o    ),
  .retire_rd_i    ( retire_rd_o    )
);

// File: source/rv_core.sv
////////////////////
// RV32I subset core top level
// Plain instruction and retire ports, one instruction in flight
////////////////////

module rv_core #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  rv_core_pkg::word_t    boot_addr_i,
  // Instruction port
  output logic                  instr_req_o,
  output rv_core_pkg::word_t    instr_addr_o,
  input  logic                  instr_rvalid_i,
  input  rv_core_pkg::word_t    instr_rdata_i,
  // Retire port
  output logic                  retire_valid_o,
  output rv_core_pkg::word_t    retire_pc_o,
  output logic                  retire_we_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::word_t    retire_wdata_o,
  output logic                  retire_illegal_o
);

  // Fetch to decode
  logic                  fetch_valid;
  rv_core_pkg::word_t    fetch_instr;
  rv_core_pkg::word_t    fetch_pc;
  // Register file ports
  rv_core_pkg::reg_idx_t rs1_addr;
  rv_core_pkg::reg_idx_t rs2_addr;
  rv_core_pkg::word_t    rs1_data;
  rv_core_pkg::word_t    rs2_data;
  logic                  rf_we;
  rv_core_pkg::reg_idx_t rf_waddr;
  rv_core_pkg::word_t    rf_wdata;
  // Writeback to fetch
  logic                  redirect;
  rv_core_pkg::word_t    redirect_pc;

  dec_ex_if dec_ex ();
  ex_wb_if  ex_wb ();

  ////////////////////
  // Fetch
  ////////////////////

  rv_fetch i_rv_fetch (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .redirect_i     ( redirect       ),
    .redirect_pc_i  ( redirect_pc    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_instr_o  ( fetch_instr    ),
    .fetch_pc_o     ( fetch_pc       )
  );

  ////////////////////
  // Decode and registers
  ////////////////////

  rv_decoder #(
    .RV32E ( RV32E )
  ) i_rv_decoder (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .fetch_valid_i ( fetch_valid ),
    .fetch_instr_i ( fetch_instr ),
    .fetch_pc_i    ( fetch_pc    ),
    .rs1_addr_o    ( rs1_addr    ),
    .rs2_addr_o    ( rs2_addr    ),
    .rs1_data_i    ( rs1_data    ),
    .rs2_data_i    ( rs2_data    ),
    .dec_ex        ( dec_ex      )
  );

  rv_regfile #(
    .RV32E ( RV32E )
  ) i_rv_regfile (
    .clk       ( clk      ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  ////////////////////
  // Execute and writeback
  ////////////////////

  rv_alu_branch i_rv_alu_branch (
    .clk    ( clk    ),
    .rst_ni ( rst_ni ),
    .dec_ex ( dec_ex ),
    .ex_wb  ( ex_wb  )
  );

  rv_writeback i_rv_writeback (
    .clk              ( clk              ),
    .rst_ni           ( rst_ni           ),
    .ex_wb            ( ex_wb            ),
    .rf_we_o          ( rf_we            ),
    .rf_waddr_o       ( rf_waddr         ),
    .rf_wdata_o       ( rf_wdata         ),
    .redirect_o       ( redirect         ),
    .redirect_pc_o    ( redirect_pc      ),
    .retire_valid_o   ( retire_valid_o   ),
    .retire_pc_o      ( retire_pc_o      ),
    .retire_we_o      ( retire_we_o      ),
    .retire_rd_o      ( retire_rd_o      ),
    .retire_wdata_o   ( retire_wdata_o   ),
    .retire_illegal_o ( retire_illegal_o )
  );

endmodule

// File: source/rv_writeback.sv
////////////////////
// Writeback: register commit, retire record and fetch redirect
// Commit and redirect are strobes during the ex_wb valid cycle
////////////////////

module rv_writeback (
  input  logic                  clk,
  input  logic                  rst_ni,
  ex_wb_if.sink                 ex_wb,
  output logic                  rf_we_o,
  output rv_core_pkg::reg_idx_t rf_waddr_o,
  output rv_core_pkg::word_t    rf_wdata_o,
  output logic                  redirect_o,
  output rv_core_pkg::word_t    redirect_pc_o,
  output logic                  retire_valid_o,
  output rv_core_pkg::word_t    retire_pc_o,
  output logic                  retire_we_o,
  output rv_core_pkg::reg_idx_t retire_rd_o,
  output rv_core_pkg::word_t    retire_wdata_o,
  output logic                  retire_illegal_o
);

  // x0 writes are dropped here and reported as no write
  assign rf_we_o    = ex_wb.valid & ex_wb.we & (ex_wb.rd != '0);
  assign rf_waddr_o = ex_wb.rd;
  assign rf_wdata_o = ex_wb.wdata;

  // Fetch registers its next request on this strobe
  assign redirect_o    = ex_wb.valid;
  assign redirect_pc_o = ex_wb.next_pc;

  ////////////////////
  // Retire record
  ////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o   <= 1'b0;
      retire_we_o      <= 1'b0;
      retire_illegal_o <= 1'b0;
    end else begin
      retire_valid_o   <= ex_wb.valid;
      retire_we_o      <= rf_we_o;
      retire_illegal_o <= ex_wb.valid & ex_wb.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_wb.valid) begin
      retire_pc_o    <= ex_wb.pc;
      retire_rd_o    <= ex_wb.rd;
      retire_wdata_o <= ex_wb.wdata;
    end
  end

endmodule

// File: source/rv_alu_branch.sv
////////////////////
// Execute stage: ALU result, branch decision and next PC
// Registers one ex_wb record per dec_ex strobe
////////////////////

module rv_alu_branch (
  input  logic      clk,
  input  logic      rst_ni,
  dec_ex_if.sink    dec_ex,
  ex_wb_if.driver   ex_wb
);

  rv_core_pkg::word_t result;
  rv_core_pkg::word_t next_pc;
  logic               cmp_eq;
  logic               taken;

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    case (dec_ex.alu_op)
      rv_isa_pkg::ALU_ADD:    result = dec_ex.operand_a + dec_ex.operand_b;
      rv_isa_pkg::ALU_SUB:    result = dec_ex.operand_a - dec_ex.operand_b;
      // Signed compare, result is 0 or 1
      rv_isa_pkg::ALU_SLT: begin
        result = {31'b0, $signed(dec_ex.operand_a) < $signed(dec_ex.operand_b)};
      end
      rv_isa_pkg::ALU_XOR:    result = dec_ex.operand_a ^ dec_ex.operand_b;
      rv_isa_pkg::ALU_OR:     result = dec_ex.operand_a | dec_ex.operand_b;
      rv_isa_pkg::ALU_AND:    result = dec_ex.operand_a & dec_ex.operand_b;
      rv_isa_pkg::ALU_PASS_B: result = dec_ex.operand_b;
      default:                result = '0;
    endcase
  end

  ////////////////////
  // Branch
  ////////////////////

  // BEQ on equal, BNE on not equal
  assign cmp_eq  = (dec_ex.cmp_a == dec_ex.cmp_b);
  assign taken   = dec_ex.is_branch & (dec_ex.branch_ne ? ~cmp_eq : cmp_eq);
  assign next_pc = taken ? dec_ex.branch_target : dec_ex.pc + rv_core_pkg::PC_STEP;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_wb.valid <= 1'b0;
    end else begin
      ex_wb.valid <= dec_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_ex.valid) begin
      ex_wb.pc      <= dec_ex.pc;
      ex_wb.rd      <= dec_ex.rd;
      // Branches and illegal records write nothing
      ex_wb.we      <= dec_ex.we & ~dec_ex.is_branch & ~dec_ex.illegal;
      ex_wb.wdata   <= result;
      ex_wb.next_pc <= next_pc;
      ex_wb.illegal <= dec_ex.illegal;
    end
  end

endmodule

// File: source/rv_regfile.sv
////////////////////
// Integer register file, 2 read ports and 1 write port
// 16 entries for RV32E, x0 reads as zero
////////////////////

module rv_regfile #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  rv_core_pkg::reg_idx_t raddr_a_i,
  input  rv_core_pkg::reg_idx_t raddr_b_i,
  output rv_core_pkg::word_t    rdata_a_o,
  output rv_core_pkg::word_t    rdata_b_o,
  input  logic                  we_i,
  input  rv_core_pkg::reg_idx_t waddr_i,
  input  rv_core_pkg::word_t    wdata_i
);

  localparam int unsigned ADDR_W   = RV32E ? 4 : 5;
  localparam int unsigned NUM_REGS = 1 << ADDR_W;

  rv_core_pkg::word_t regs_q [NUM_REGS];

  // Write port, x0 never written
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i[ADDR_W-1:0]] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i[ADDR_W-1:0]];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i[ADDR_W-1:0]];

endmodule

// File: source/rv_decoder.sv
////////////////////
// Decode of the RV32I subset, operand read and branch target
// Registers one dec_ex record per fetched word
////////////////////

module rv_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_valid_i,
  input  rv_core_pkg::word_t    fetch_instr_i,
  input  rv_core_pkg::word_t    fetch_pc_i,
  output rv_core_pkg::reg_idx_t rs1_addr_o,
  output rv_core_pkg::reg_idx_t rs2_addr_o,
  input  rv_core_pkg::word_t    rs1_data_i,
  input  rv_core_pkg::word_t    rs2_data_i,
  dec_ex_if.driver              dec_ex
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [6:0]            funct7_rest;
  rv_core_pkg::reg_idx_t rd;
  rv_core_pkg::reg_idx_t rs1;
  rv_core_pkg::reg_idx_t rs2;
  rv_core_pkg::word_t    imm_i;
  rv_core_pkg::word_t    imm_u;
  rv_core_pkg::word_t    imm_b;
  rv_isa_pkg::alu_op_e   alu_op;
  rv_core_pkg::word_t    operand_b;
  logic                  we;
  logic                  is_branch;
  logic                  illegal;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  bad_reg;

  // Instruction fields
  assign opcode = fetch_instr_i[6:0];
  assign rd     = fetch_instr_i[11:7];
  assign funct3 = fetch_instr_i[14:12];
  assign rs1    = fetch_instr_i[19:15];
  assign rs2    = fetch_instr_i[24:20];
  assign funct7 = fetch_instr_i[31:25];

  // funct7 with the SUB marker masked, must be zero for OP
  assign funct7_rest = funct7 & ~(7'd1 << rv_isa_pkg::F7_SUB_BIT);

  // Immediates, all sign-extended from bit 31
  assign imm_i = {{20{fetch_instr_i[31]}}, fetch_instr_i[31:20]};
  assign imm_u = {fetch_instr_i[31:12], 12'b0};
  assign imm_b = {{19{fetch_instr_i[31]}}, fetch_instr_i[31], fetch_instr_i[7],
                  fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  ////////////////////
  // Main decode
  ////////////////////

  always_comb begin
    alu_op    = rv_isa_pkg::ALU_ADD;
    operand_b = rs2_data_i;
    we        = 1'b0;
    is_branch = 1'b0;
    illegal   = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        alu_op    = rv_isa_pkg::ALU_PASS_B;
        operand_b = imm_u;
        we        = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        operand_b = imm_i;
        we        = 1'b1;
        use_rs1   = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: alu_op = rv_isa_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT:     alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::ALU_AND;
          default:                illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OPC_OP: begin
        we      = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            alu_op = funct7[rv_isa_pkg::F7_SUB_BIT] ? rv_isa_pkg::ALU_SUB
                                                    : rv_isa_pkg::ALU_ADD;
          end
          rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
          default:            illegal = 1'b1;
        endcase
        // SUB marker only valid on ADD/SUB, no other funct7 bits
        if (funct7_rest != 7'd0) begin
          illegal = 1'b1;
        end
        if (funct7[rv_isa_pkg::F7_SUB_BIT] && funct3 != rv_isa_pkg::F3_ADD_SUB) begin
          illegal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        if (funct3 != rv_isa_pkg::F3_BEQ && funct3 != rv_isa_pkg::F3_BNE) begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // RV32E has no x16..x31
  assign bad_reg = RV32E & ((use_rs1 & rs1[4]) | (use_rs2 & rs2[4]) | (we & rd[4]));

  ////////////////////
  // dec_ex register
  ////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_ex.valid <= 1'b0;
    end else begin
      dec_ex.valid <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i) begin
      dec_ex.alu_op        <= alu_op;
      dec_ex.operand_a     <= rs1_data_i;
      dec_ex.operand_b     <= operand_b;
      dec_ex.cmp_a         <= rs1_data_i;
      dec_ex.cmp_b         <= rs2_data_i;
      dec_ex.is_branch     <= is_branch & ~(illegal | bad_reg);
      dec_ex.branch_ne     <= (funct3 == rv_isa_pkg::F3_BNE);
      dec_ex.branch_target <= fetch_pc_i + imm_b;
      dec_ex.pc            <= fetch_pc_i;
      dec_ex.rd            <= rd;
      // Illegal never writes
      dec_ex.we            <= we & ~(illegal | bad_reg);
      dec_ex.illegal       <= illegal | bad_reg;
    end
  end

endmodule

// File: source/rv_fetch.sv
////////////////////
// Instruction fetch with one request in flight
// Requests at boot and on each redirect, strobes the returned word to decode
////////////////////

module rv_fetch (
  input  logic               clk,
  input  logic               rst_ni,
  input  rv_core_pkg::word_t boot_addr_i,
  input  logic               redirect_i,
  input  rv_core_pkg::word_t redirect_pc_i,
  input  logic               instr_rvalid_i,
  input  rv_core_pkg::word_t instr_rdata_i,
  output logic               instr_req_o,
  output rv_core_pkg::word_t instr_addr_o,
  output logic               fetch_valid_o,
  output rv_core_pkg::word_t fetch_instr_o,
  output rv_core_pkg::word_t fetch_pc_o
);

  logic               boot_pending_q;
  logic               req_q;
  logic               outstanding_q;
  logic               fetch_valid_q;
  logic               capture;
  rv_core_pkg::word_t addr_q;
  rv_core_pkg::word_t instr_q;
  rv_core_pkg::word_t pc_q;

  // Only a word we asked for is taken
  assign capture = instr_rvalid_i & outstanding_q;

  ////////////////////
  // Request control
  ////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_pending_q <= 1'b1;
      req_q          <= 1'b0;
      outstanding_q  <= 1'b0;
      fetch_valid_q  <= 1'b0;
      addr_q         <= rv_core_pkg::BOOT_ADDR_RST;
    end else begin
      // One boot request, later ones come from writeback
      boot_pending_q <= 1'b0;
      req_q          <= boot_pending_q | redirect_i;
      if (boot_pending_q) begin
        addr_q <= boot_addr_i;
      end else if (redirect_i) begin
        addr_q <= redirect_pc_i;
      end
      // Busy from the request strobe until the answer
      outstanding_q <= req_q | (outstanding_q & ~instr_rvalid_i);
      fetch_valid_q <= capture;
    end
  end

  // Returned word plus the address it came from
  always_ff @(posedge clk) begin
    if (capture) begin
      instr_q <= instr_rdata_i;
      pc_q    <= addr_q;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = addr_q;
  assign fetch_valid_o = fetch_valid_q;
  assign fetch_instr_o = instr_q;
  assign fetch_pc_o    = pc_q;

endmodule

// File: source/rv_stage_if.sv
////////////////////
// Stage-to-stage records of the core
// Decode to execute, then execute to writeback; valid is a one-cycle strobe
////////////////////

// Decoded instruction with its operands
interface dec_ex_if;
  logic                valid;
  rv_isa_pkg::alu_op_e alu_op;
  rv_core_pkg::word_t  operand_a;
  rv_core_pkg::word_t  operand_b;
  // Branch comparison operands and target
  rv_core_pkg::word_t  cmp_a;
  rv_core_pkg::word_t  cmp_b;
  logic                is_branch;
  logic                branch_ne;
  rv_core_pkg::word_t  branch_target;
  // Retire bookkeeping
  rv_core_pkg::word_t  pc;
  rv_core_pkg::reg_idx_t rd;
  logic                we;
  logic                illegal;

  modport driver (
    output valid, alu_op, operand_a, operand_b, cmp_a, cmp_b,
           is_branch, branch_ne, branch_target, pc, rd, we, illegal
  );

  modport sink (
    input  valid, alu_op, operand_a, operand_b, cmp_a, cmp_b,
           is_branch, branch_ne, branch_target, pc, rd, we, illegal
  );
endinterface

// Executed result and the PC that follows it
interface ex_wb_if;
  logic                  valid;
  rv_core_pkg::word_t    pc;
  rv_core_pkg::reg_idx_t rd;
  logic                  we;
  rv_core_pkg::word_t    wdata;
  rv_core_pkg::word_t    next_pc;
  logic                  illegal;

  modport driver (
    output valid, pc, rd, we, wdata, next_pc, illegal
  );

  modport sink (
    input  valid, pc, rd, we, wdata, next_pc, illegal
  );
endinterface

// File: source/rv_isa_pkg.sv
////////////////////
// Encodings of the supported RV32I subset and the ALU operation type
// Shared by the decoder, the execute stage and the stage interfaces
////////////////////

package rv_isa_pkg;

  ////////////////////
  // Major opcodes
  ////////////////////

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  ////////////////////
  // funct3 and funct7
  ////////////////////

  // ALU group, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch group
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // Bit of funct7 that turns ADD into SUB
  localparam int unsigned F7_SUB_BIT = 5;

  // ALU operations, PASS_B forwards operand b for LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_SLT    = 3'd2,
    ALU_XOR    = 3'd3,
    ALU_OR     = 3'd4,
    ALU_AND    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

endpackage

// File: source/rv_core_pkg.sv
////////////////////
// Core-wide widths, word and register-index types and reset constants
// Every design file reaches these through rv_core_pkg:: scoped names
////////////////////

package rv_core_pkg;

  // Datapath width
  localparam int unsigned XLEN = 32;

  // Register index width, wide enough for the full RV32I file
  localparam int unsigned REG_IDX_W = 5;

  // Data or address word
  typedef logic [XLEN-1:0] word_t;

  // Register index as found in the instruction fields
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Sequential PC increment, no compressed instructions
  localparam word_t PC_STEP = 32'd4;

  // Fetch address held while in reset
  // Replaced by boot_addr_i on the first cycle after release
  localparam word_t BOOT_ADDR_RST = 32'h0000_0000;

endpackage
